// File: src.f
logic/router_pkg.sv
logic/dm_cache.sv
logic/uncached_port.sv
logic/bus_arbiter.sv
logic/mem_router.sv
dv/mem_router_asserts.sv
dv/tb_mem_router.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_router
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_mem_router.sv
`timescale 1ns/1ps

module tb_mem_router;

  localparam int TIMEOUT = 200;
  localparam int MAX_ROWS = 20;
  // memory fill pattern key, each word is its address XOR this
  localparam router_pkg::data_t FILL_KEY = 32'h3C5A_96E1;

  logic              clk = 1'b0;
  logic              rst;
  logic              cpu_req_valid_i;
  logic              cpu_req_ready_o;
  logic              cpu_req_we_i;
  router_pkg::addr_t cpu_req_addr_i;
  router_pkg::data_t cpu_req_wdata_i;
  logic              cpu_rsp_valid_o;
  logic              cpu_rsp_ready_i;
  router_pkg::data_t cpu_rsp_rdata_o;
  logic              mem_req_valid_o;
  logic              mem_req_ready_i = 1'b0;
  logic              mem_req_we_o;
  router_pkg::addr_t mem_req_addr_o;
  router_pkg::data_t mem_req_wdata_o;
  logic              mem_rsp_valid_i = 1'b0;
  router_pkg::data_t mem_rsp_rdata_i = '0;

  // memory model state
  router_pkg::data_t mem [router_pkg::addr_t];
  logic              bus_busy = 1'b0;
  int                lat_left = 0;
  router_pkg::data_t rsp_word = '0;
  int                bus_reads = 0;
  int                bus_writes = 0;

  // stimulus table
  int                n_rows = 0;
  logic              tbl_we    [MAX_ROWS];
  router_pkg::addr_t tbl_addr  [MAX_ROWS];
  router_pkg::data_t tbl_wdata [MAX_ROWS];
  router_pkg::data_t tbl_rdata [MAX_ROWS];
  int                tbl_reads [MAX_ROWS];

  mem_router dut0 (.*);

  always #5 clk = ~clk;

  function automatic router_pkg::data_t fill_word(input router_pkg::addr_t addr);
    return addr ^ FILL_KEY;
  endfunction

  function automatic router_pkg::data_t mem_word(input router_pkg::addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return fill_word(addr);
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_data(input string name, input router_pkg::data_t got,
                            input router_pkg::data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // single outstanding bus transaction, random ready and 0 to 3 cycles latency
  always @(posedge clk) begin
    if (rst) begin
      mem_req_ready_i <= 1'b0;
      mem_rsp_valid_i <= 1'b0;
      mem_rsp_rdata_i <= '0;
      bus_busy = 1'b0;
      lat_left = 0;
    end else begin
      mem_rsp_valid_i <= 1'b0;
      if (!bus_busy) begin
        if (mem_req_valid_o && mem_req_ready_i) begin
          bus_busy = 1'b1;
          lat_left = $urandom % 4;
          mem_req_ready_i <= 1'b0;
          if (mem_req_we_o) begin
            mem[mem_req_addr_o] = mem_req_wdata_o;
            bus_writes = bus_writes + 1;
            rsp_word = '0;
          end else begin
            rsp_word = mem_word(mem_req_addr_o);
            bus_reads = bus_reads + 1;
          end
        end else begin
          mem_req_ready_i <= ($urandom % 3) != 0;
        end
      end else if (lat_left == 0) begin
        mem_rsp_valid_i <= 1'b1;
        mem_rsp_rdata_i <= rsp_word;
        bus_busy = 1'b0;
      end else begin
        lat_left = lat_left - 1;
      end
    end
  end

  task automatic add_row(input logic we, input router_pkg::addr_t addr,
                         input router_pkg::data_t wdata, input router_pkg::data_t rdata,
                         input int reads);
    tbl_we[n_rows]    = we;
    tbl_addr[n_rows]  = addr;
    tbl_wdata[n_rows] = wdata;
    tbl_rdata[n_rows] = rdata;
    tbl_reads[n_rows] = reads;
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    // cacheable miss, then hit
    add_row(1'b0, 32'h8000_0040, '0, fill_word(32'h8000_0040), 1);
    add_row(1'b0, 32'h8000_0040, '0, fill_word(32'h8000_0040), 0);
    // uncached reads always go to the bus
    add_row(1'b0, 32'h1000_0000, '0, fill_word(32'h1000_0000), 1);
    add_row(1'b0, 32'h1000_0000, '0, fill_word(32'h1000_0000), 1);
    // write hit updates the line
    add_row(1'b1, 32'h8000_0040, 32'hDEAD_BEEF, '0, 0);
    add_row(1'b0, 32'h8000_0040, '0, 32'hDEAD_BEEF, 0);
    // posted write miss right before a bypass read, both want the bus
    add_row(1'b1, 32'h8000_0080, 32'h1234_5678, '0, 0);
    add_row(1'b0, 32'h2000_0010, '0, fill_word(32'h2000_0010), 1);
    // same index as 0x8000_0040, refill sees the written-through word
    add_row(1'b0, 32'h8000_0080, '0, 32'h1234_5678, 1);
    add_row(1'b0, 32'h8000_0040, '0, 32'hDEAD_BEEF, 1);
    add_row(1'b1, 32'h1000_0000, 32'hCAFE_F00D, '0, 0);
    add_row(1'b0, 32'h1000_0000, '0, 32'hCAFE_F00D, 1);
    // region boundary
    add_row(1'b0, 32'h87FF_FFFC, '0, fill_word(32'h87FF_FFFC), 1);
    add_row(1'b0, 32'h87FF_FFFC, '0, fill_word(32'h87FF_FFFC), 0);
    add_row(1'b0, 32'h8800_0000, '0, fill_word(32'h8800_0000), 1);
    add_row(1'b0, 32'h8800_0000, '0, fill_word(32'h8800_0000), 1);
  endtask

  task automatic drive_request(input int i);
    cpu_req_valid_i <= 1'b1;
    cpu_req_we_i    <= tbl_we[i];
    cpu_req_addr_i  <= tbl_addr[i];
    cpu_req_wdata_i <= tbl_wdata[i];
  endtask

  // waits for the response, presents the next row behind it, holds the response
  // back for hold cycles, then takes it
  task automatic take_response(input int i, input int hold,
                               output router_pkg::data_t rdata);
    int                waited;
    router_pkg::data_t first;
    waited = 0;
    @(negedge clk);
    while (!cpu_rsp_valid_o) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        report_failure("no response from the router within the timeout");
      end
      @(negedge clk);
    end
    first = cpu_rsp_rdata_o;
    @(posedge clk);
    if (i + 1 < n_rows) begin
      drive_request(i + 1);
    end
    if (hold == 0) begin
      // ready was already up, this edge takes the response
      cpu_rsp_ready_i <= 1'b0;
    end else begin
      repeat (hold) begin
        @(negedge clk);
        if (!cpu_rsp_valid_o) begin
          report_failure("response valid dropped while the CPU held it back");
        end
        check_data("cpu_rsp_rdata_o", cpu_rsp_rdata_o, first);
        if (cpu_req_ready_o) begin
          report_failure("router ready for a request while a response is pending");
        end
      end
      @(posedge clk);
      cpu_rsp_ready_i <= 1'b1;
      @(posedge clk);
      cpu_rsp_ready_i <= 1'b0;
    end
    rdata = first;
  endtask

  // entered on a falling edge with the request of row i already presented
  task automatic run_row(input int i);
    int                reads_before;
    int                waited;
    int                hold;
    router_pkg::data_t got;
    reads_before = bus_reads;
    // posted writes are answered at once so the drain races the next request
    hold = tbl_we[i] ? 0 : $urandom % 4;
    waited = 0;
    while (!cpu_req_ready_o) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        report_failure($sformatf("request of row %0d was not accepted in time", i));
      end
      @(negedge clk);
    end
    @(posedge clk);
    cpu_req_valid_i <= 1'b0;
    cpu_rsp_ready_i <= (hold == 0);
    take_response(i, hold, got);
    @(negedge clk);
    check_data("cpu_rsp_rdata_o", got, tbl_rdata[i]);
    check_count("bus_reads", bus_reads - reads_before, tbl_reads[i]);
  endtask

  initial begin
    int exp_writes;
    int waited;
    void'($urandom(67919));
    rst             <= 1'b1;
    cpu_req_valid_i <= 1'b0;
    cpu_req_we_i    <= 1'b0;
    cpu_req_addr_i  <= '0;
    cpu_req_wdata_i <= '0;
    cpu_rsp_ready_i <= 1'b0;
    build_table();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    drive_request(0);
    @(negedge clk);

    exp_writes = 0;
    for (int i = 0; i < n_rows; i++) begin
      if (tbl_we[i]) begin
        exp_writes = exp_writes + 1;
      end
      run_row(i);
    end

    // let any posted write finish on the bus
    waited = 0;
    @(negedge clk);
    while (mem_req_valid_o || bus_busy || mem_rsp_valid_i) begin
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        report_failure("memory bus did not go idle after the last request");
      end
      @(negedge clk);
    end
    check_count("bus_writes", bus_writes, exp_writes);
    check_data("mem[0x80000040]", mem_word(32'h8000_0040), 32'hDEAD_BEEF);
    check_data("mem[0x80000080]", mem_word(32'h8000_0080), 32'h1234_5678);
    check_data("mem[0x10000000]", mem_word(32'h1000_0000), 32'hCAFE_F00D);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: dv/mem_router_asserts.sv
`timescale 1ns/1ps

module mem_router_asserts (
  input logic              clk,
  input logic              rst,
  input logic              bus_valid_i,
  input logic              bus_ready_i,
  input logic              bus_we_i,
  input router_pkg::addr_t bus_addr_i,
  input router_pkg::data_t bus_wdata_i,
  input logic              bus_rsp_valid_i,
  input logic              cpu_valid_i,
  input logic              cpu_ready_i,
  input logic              rsp_valid_i,
  input logic              rsp_ready_i
);

  logic outstanding_q;
  logic pending_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding_q <= 1'b0;
      pending_q     <= 1'b0;
    end else begin
      if (bus_rsp_valid_i) begin
        outstanding_q <= 1'b0;
      end else if (bus_valid_i && bus_ready_i) begin
        outstanding_q <= 1'b1;
      end
      if (cpu_valid_i && cpu_ready_i) begin
        pending_q <= 1'b1;
      end else if (rsp_valid_i && rsp_ready_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  // a stalled bus request keeps its valid and fields
  assert property (@(posedge clk) disable iff (rst)
    bus_valid_i && !bus_ready_i |=> bus_valid_i && $stable(bus_we_i) &&
      $stable(bus_addr_i) && $stable(bus_wdata_i))
    else $error("memory bus request changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
    bus_rsp_valid_i |-> outstanding_q)
    else $error("memory response without an outstanding request");

  assert property (@(posedge clk) disable iff (rst)
    pending_q |-> !cpu_ready_i)
    else $error("router ready while a response is pending");

endmodule

bind mem_router mem_router_asserts asserts0 (
  .clk             (clk),
  .rst             (rst),
  .bus_valid_i     (mem_req_valid_o),
  .bus_ready_i     (mem_req_ready_i),
  .bus_we_i        (mem_req_we_o),
  .bus_addr_i      (mem_req_addr_o),
  .bus_wdata_i     (mem_req_wdata_o),
  .bus_rsp_valid_i (mem_rsp_valid_i),
  .cpu_valid_i     (cpu_req_valid_i),
  .cpu_ready_i     (cpu_req_ready_o),
  .rsp_valid_i     (cpu_rsp_valid_o),
  .rsp_ready_i     (cpu_rsp_ready_i)
);

// File: logic/mem_router.sv
`timescale 1ns/1ps

module mem_router (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_req_valid_i,
  output logic              cpu_req_ready_o,
  input  logic              cpu_req_we_i,
  input  router_pkg::addr_t cpu_req_addr_i,
  input  router_pkg::data_t cpu_req_wdata_i,
  output logic              cpu_rsp_valid_o,
  input  logic              cpu_rsp_ready_i,
  output router_pkg::data_t cpu_rsp_rdata_o,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output logic              mem_req_we_o,
  output router_pkg::addr_t mem_req_addr_o,
  output router_pkg::data_t mem_req_wdata_o,
  input  logic              mem_rsp_valid_i,
  input  router_pkg::data_t mem_rsp_rdata_i
);

  logic is_cacheable;
  logic pending_q;
  // 1 when the outstanding request went to the cache
  logic route_q;

  logic              c_req_valid, c_req_ready, c_rsp_valid, c_rsp_ready;
  logic              u_req_valid, u_req_ready, u_rsp_valid, u_rsp_ready;
  router_pkg::data_t c_rsp_rdata, u_rsp_rdata;

  // master to arbiter wires, cb_ from the cache and ub_ from the bypass
  logic              cb_req_valid, cb_req_ready, cb_req_we, cb_rsp_valid;
  logic              ub_req_valid, ub_req_ready, ub_req_we, ub_rsp_valid;
  router_pkg::addr_t cb_req_addr, ub_req_addr;
  router_pkg::data_t cb_req_wdata, ub_req_wdata, cb_rsp_rdata, ub_rsp_rdata;

  assign is_cacheable = (cpu_req_addr_i >= router_pkg::CACHE_BASE) &&
                        (cpu_req_addr_i < router_pkg::CACHE_LIMIT);

  assign c_req_valid = cpu_req_valid_i && !pending_q && is_cacheable;
  assign u_req_valid = cpu_req_valid_i && !pending_q && !is_cacheable;
  assign cpu_req_ready_o = !pending_q && (is_cacheable ? c_req_ready : u_req_ready);

  // response side follows the path chosen at acceptance
  assign cpu_rsp_valid_o = route_q ? c_rsp_valid : u_rsp_valid;
  assign cpu_rsp_rdata_o = route_q ? c_rsp_rdata : u_rsp_rdata;
  assign c_rsp_ready = cpu_rsp_ready_i && route_q;
  assign u_rsp_ready = cpu_rsp_ready_i && !route_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      route_q   <= 1'b0;
    end else if (cpu_req_valid_i && cpu_req_ready_o) begin
      pending_q <= 1'b1;
      route_q   <= is_cacheable;
    end else if (cpu_rsp_valid_o && cpu_rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  dm_cache cache0 (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (c_req_valid),
    .req_ready_o     (c_req_ready),
    .req_we_i        (cpu_req_we_i),
    .req_addr_i      (cpu_req_addr_i),
    .req_wdata_i     (cpu_req_wdata_i),
    .rsp_valid_o     (c_rsp_valid),
    .rsp_ready_i     (c_rsp_ready),
    .rsp_rdata_o     (c_rsp_rdata),
    .bus_req_valid_o (cb_req_valid),
    .bus_req_ready_i (cb_req_ready),
    .bus_req_we_o    (cb_req_we),
    .bus_req_addr_o  (cb_req_addr),
    .bus_req_wdata_o (cb_req_wdata),
    .bus_rsp_valid_i (cb_rsp_valid),
    .bus_rsp_rdata_i (cb_rsp_rdata)
  );

  uncached_port bypass0 (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (u_req_valid),
    .req_ready_o     (u_req_ready),
    .req_we_i        (cpu_req_we_i),
    .req_addr_i      (cpu_req_addr_i),
    .req_wdata_i     (cpu_req_wdata_i),
    .rsp_valid_o     (u_rsp_valid),
    .rsp_ready_i     (u_rsp_ready),
    .rsp_rdata_o     (u_rsp_rdata),
    .bus_req_valid_o (ub_req_valid),
    .bus_req_ready_i (ub_req_ready),
    .bus_req_we_o    (ub_req_we),
    .bus_req_addr_o  (ub_req_addr),
    .bus_req_wdata_o (ub_req_wdata),
    .bus_rsp_valid_i (ub_rsp_valid),
    .bus_rsp_rdata_i (ub_rsp_rdata)
  );

  bus_arbiter arb0 (
    .clk             (clk),
    .rst             (rst),
    .c_req_valid_i   (cb_req_valid),
    .c_req_ready_o   (cb_req_ready),
    .c_req_we_i      (cb_req_we),
    .c_req_addr_i    (cb_req_addr),
    .c_req_wdata_i   (cb_req_wdata),
    .c_rsp_valid_o   (cb_rsp_valid),
    .c_rsp_rdata_o   (cb_rsp_rdata),
    .b_req_valid_i   (ub_req_valid),
    .b_req_ready_o   (ub_req_ready),
    .b_req_we_i      (ub_req_we),
    .b_req_addr_i    (ub_req_addr),
    .b_req_wdata_i   (ub_req_wdata),
    .b_rsp_valid_o   (ub_rsp_valid),
    .b_rsp_rdata_o   (ub_rsp_rdata),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i)
  );

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  logic              c_req_valid_i,
  output logic              c_req_ready_o,
  input  logic              c_req_we_i,
  input  router_pkg::addr_t c_req_addr_i,
  input  router_pkg::data_t c_req_wdata_i,
  output logic              c_rsp_valid_o,
  output router_pkg::data_t c_rsp_rdata_o,
  input  logic              b_req_valid_i,
  output logic              b_req_ready_o,
  input  logic              b_req_we_i,
  input  router_pkg::addr_t b_req_addr_i,
  input  router_pkg::data_t b_req_wdata_i,
  output logic              b_rsp_valid_o,
  output router_pkg::data_t b_rsp_rdata_o,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output logic              mem_req_we_o,
  output router_pkg::addr_t mem_req_addr_o,
  output router_pkg::data_t mem_req_wdata_o,
  input  logic              mem_rsp_valid_i,
  input  router_pkg::data_t mem_rsp_rdata_i
);

  router_pkg::bus_owner_t owner_q;
  router_pkg::bus_owner_t last_q;
  router_pkg::bus_owner_t grant;
  router_pkg::bus_owner_t cur;
  // owner's request accepted, response still due
  logic                   out_q;

  always_comb begin
    grant = router_pkg::OWN_NONE;
    if (c_req_valid_i && b_req_valid_i) begin
      // tie goes to whoever did not have the bus last time
      if (last_q == router_pkg::OWN_CACHE) begin
        grant = router_pkg::OWN_BYPASS;
      end else begin
        grant = router_pkg::OWN_CACHE;
      end
    end else if (c_req_valid_i) begin
      grant = router_pkg::OWN_CACHE;
    end else if (b_req_valid_i) begin
      grant = router_pkg::OWN_BYPASS;
    end
    cur = owner_q;
    if (owner_q == router_pkg::OWN_NONE) begin
      cur = grant;
    end
  end

  always_comb begin
    mem_req_valid_o = 1'b0;
    mem_req_we_o    = c_req_we_i;
    mem_req_addr_o  = c_req_addr_i;
    mem_req_wdata_o = c_req_wdata_i;
    case (cur)
      router_pkg::OWN_CACHE: mem_req_valid_o = c_req_valid_i && !out_q;
      router_pkg::OWN_BYPASS: begin
        mem_req_valid_o = b_req_valid_i && !out_q;
        mem_req_we_o    = b_req_we_i;
        mem_req_addr_o  = b_req_addr_i;
        mem_req_wdata_o = b_req_wdata_i;
      end
      default: mem_req_valid_o = 1'b0;
    endcase
  end

  assign c_req_ready_o = (cur == router_pkg::OWN_CACHE) && !out_q && mem_req_ready_i;
  assign b_req_ready_o = (cur == router_pkg::OWN_BYPASS) && !out_q && mem_req_ready_i;

  // bus response goes to the owner only
  assign c_rsp_valid_o = mem_rsp_valid_i && (cur == router_pkg::OWN_CACHE);
  assign b_rsp_valid_o = mem_rsp_valid_i && (cur == router_pkg::OWN_BYPASS);
  assign c_rsp_rdata_o = mem_rsp_rdata_i;
  assign b_rsp_rdata_o = mem_rsp_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q <= router_pkg::OWN_NONE;
      last_q  <= router_pkg::OWN_BYPASS;
      out_q   <= 1'b0;
    end else begin
      // lock on first presentation so a stalled request keeps its fields
      if (mem_req_valid_o) begin
        owner_q <= cur;
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        out_q <= 1'b1;
      end
      if (mem_rsp_valid_i) begin
        owner_q <= router_pkg::OWN_NONE;
        out_q   <= 1'b0;
        last_q  <= cur;
      end
    end
  end

endmodule

// File: logic/uncached_port.sv
`timescale 1ns/1ps

module uncached_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_we_i,
  input  router_pkg::addr_t req_addr_i,
  input  router_pkg::data_t req_wdata_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output router_pkg::data_t rsp_rdata_o,
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  output logic              bus_req_we_o,
  output router_pkg::addr_t bus_req_addr_o,
  output router_pkg::data_t bus_req_wdata_o,
  input  logic              bus_rsp_valid_i,
  input  router_pkg::data_t bus_rsp_rdata_i
);

  // request on the bus, waiting for the bus, holding the response
  logic req_pend_q;
  logic wait_q;
  logic rsp_valid_q;

  logic              we_q;
  router_pkg::addr_t addr_q;
  router_pkg::data_t wdata_q;
  router_pkg::data_t rdata_q;

  assign req_ready_o     = !(req_pend_q || wait_q || rsp_valid_q);
  assign bus_req_valid_o = req_pend_q;
  assign bus_req_we_o    = we_q;
  assign bus_req_addr_o  = addr_q;
  assign bus_req_wdata_o = wdata_q;
  assign rsp_valid_o     = rsp_valid_q;
  assign rsp_rdata_o     = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_pend_q  <= 1'b0;
      wait_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        req_pend_q <= 1'b1;
      end
      if (bus_req_valid_o && bus_req_ready_i) begin
        req_pend_q <= 1'b0;
        wait_q     <= 1'b1;
      end
      if (bus_rsp_valid_i) begin
        wait_q      <= 1'b0;
        rsp_valid_q <= 1'b1;
      end
      if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_we_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    // writes answer with zero data
    if (bus_rsp_valid_i) begin
      rdata_q <= we_q ? '0 : bus_rsp_rdata_i;
    end
  end

endmodule

// File: logic/dm_cache.sv
`timescale 1ns/1ps

module dm_cache (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_we_i,
  input  router_pkg::addr_t req_addr_i,
  input  router_pkg::data_t req_wdata_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output router_pkg::data_t rsp_rdata_o,
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  output logic              bus_req_we_o,
  output router_pkg::addr_t bus_req_addr_o,
  output router_pkg::data_t bus_req_wdata_o,
  input  logic              bus_rsp_valid_i,
  input  router_pkg::data_t bus_rsp_rdata_i
);

  router_pkg::cache_state_t state_q;

  logic [router_pkg::LINES-1:0] line_valid_q;
  router_pkg::tag_t             tag_arr  [router_pkg::LINES];
  router_pkg::data_t            data_arr [router_pkg::LINES];

  // one-entry write buffer
  logic              wb_full_q;
  router_pkg::addr_t wb_addr_q;
  router_pkg::data_t wb_data_q;

  router_pkg::addr_t miss_addr_q;
  router_pkg::data_t rsp_rdata_q;
  // bus request accepted, waiting for its response
  logic              bus_busy_q;

  router_pkg::index_t req_idx, miss_idx;
  router_pkg::tag_t   req_tag, miss_tag;
  logic               hit, accept, drain_done, refill_done;

  assign req_idx  = req_addr_i[router_pkg::IDX_W+1:2];
  assign req_tag  = req_addr_i[router_pkg::ADDR_W-1:router_pkg::IDX_W+2];
  assign miss_idx = miss_addr_q[router_pkg::IDX_W+1:2];
  assign miss_tag = miss_addr_q[router_pkg::ADDR_W-1:router_pkg::IDX_W+2];
  assign hit      = line_valid_q[req_idx] && (tag_arr[req_idx] == req_tag);

  assign req_ready_o = (state_q == router_pkg::C_IDLE) && !wb_full_q;
  assign accept      = req_valid_i && req_ready_o;
  assign rsp_valid_o = (state_q == router_pkg::C_RSP);
  assign rsp_rdata_o = rsp_rdata_q;

  // the buffered write goes first, a refill only issues on an empty buffer
  assign bus_req_valid_o = !bus_busy_q && (wb_full_q || state_q == router_pkg::C_REFILL);
  assign bus_req_we_o    = wb_full_q;
  assign bus_req_addr_o  = wb_full_q ? wb_addr_q : miss_addr_q;
  assign bus_req_wdata_o = wb_data_q;

  assign drain_done  = bus_rsp_valid_i && wb_full_q;
  assign refill_done = bus_rsp_valid_i && !wb_full_q && (state_q == router_pkg::C_REFILL);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= router_pkg::C_IDLE;
      line_valid_q <= '0;
      wb_full_q    <= 1'b0;
      bus_busy_q   <= 1'b0;
    end else begin
      if (bus_req_valid_o && bus_req_ready_i) begin
        bus_busy_q <= 1'b1;
      end
      if (bus_rsp_valid_i) begin
        bus_busy_q <= 1'b0;
      end
      if (drain_done) begin
        wb_full_q <= 1'b0;
      end
      case (state_q)
        router_pkg::C_IDLE: begin
          if (accept) begin
            if (req_we_i) begin
              // write is posted, answer right away
              wb_full_q <= 1'b1;
              state_q   <= router_pkg::C_RSP;
            end else if (hit) begin
              state_q <= router_pkg::C_RSP;
            end else begin
              state_q <= router_pkg::C_REFILL;
            end
          end
        end
        router_pkg::C_REFILL: begin
          if (refill_done) begin
            line_valid_q[miss_idx] <= 1'b1;
            state_q                <= router_pkg::C_RSP;
          end
        end
        router_pkg::C_RSP: begin
          if (rsp_ready_i) begin
            state_q <= router_pkg::C_IDLE;
          end
        end
        default: state_q <= router_pkg::C_IDLE;
      endcase
    end
  end

  // arrays and payload
  always_ff @(posedge clk) begin
    if (accept) begin
      if (req_we_i) begin
        wb_addr_q   <= req_addr_i;
        wb_data_q   <= req_wdata_i;
        rsp_rdata_q <= '0;
        // no allocate on a write miss
        if (hit) begin
          data_arr[req_idx] <= req_wdata_i;
        end
      end else begin
        miss_addr_q <= req_addr_i;
        rsp_rdata_q <= data_arr[req_idx];
      end
    end
    if (refill_done) begin
      tag_arr[miss_idx]  <= miss_tag;
      data_arr[miss_idx] <= bus_rsp_rdata_i;
      rsp_rdata_q        <= bus_rsp_rdata_i;
    end
  end

endmodule

// File: logic/router_pkg.sv
package router_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // cache geometry, one word per line
  localparam int LINES = 16;
  localparam int IDX_W = 4;
  localparam int TAG_W = ADDR_W - 2 - IDX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // index is addr[5:2], tag is addr[31:6]
  typedef logic [IDX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;

  // cacheable window: base inclusive, limit exclusive
  localparam addr_t CACHE_BASE  = 32'h8000_0000;
  localparam addr_t CACHE_LIMIT = 32'h8800_0000;

  typedef enum logic [1:0] {
    C_IDLE,
    C_REFILL,
    C_RSP
  } cache_state_t;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_CACHE,
    OWN_BYPASS
  } bus_owner_t;

endpackage
